//--- include/lamp_macros.svh
/*
 * lamp macros: mode byte codes and colour wheel constants
 */
`ifndef LAMP_MACROS_SVH
`define LAMP_MACROS_SVH

// mode byte codes from the lighting front end
// four levels straight to the outputs
`define LAMP_MODE_PASS 8'h21
// colour wheel walk up to colorIdx
`define LAMP_MODE_WHEEL 8'hA4

// wheel positions per segment, 7 segments cover 0..255
`define HUE_SEG_LEN 6'd36

// channel increment per ramp step
// 36 steps of 7 stay just under full scale
`define HUE_STEP 8'd7

// index of the final segment, pure red
`define HUE_LAST_SEG 3'd6

`endif

//--- design/lampPkg.sv
/*
 * lampPkg: job and sample types shared by the RGBW lamp pipeline stages
 */
package lampPkg;

    // kind of job in flight
    typedef enum logic {
        opPass,
        opWheel
    } lampOp;

    // hue ramp FSM states
    typedef enum logic [1:0] {
        rsIdle,
        rsStep,
        rsDone
    } rampState;

    // job launched by the capture stage
    typedef struct packed {
        lampOp       op;
        logic [7:0]  intensity;
        logic [7:0]  colorIdx;
        logic [15:0] whiteLvl;
        logic [15:0] redLvl;
        logic [15:0] greenLvl;
        logic [15:0] blueLvl;
    } lampJob;

    // per-stage sample, 8-bit colour plus raw levels for passthrough
    typedef struct packed {
        lampOp       op;
        logic [7:0]  intensity;
        logic [7:0]  red;
        logic [7:0]  green;
        logic [7:0]  blue;
        logic [7:0]  white;
        logic [15:0] whiteRaw;
        logic [15:0] redRaw;
        logic [15:0] greenRaw;
        logic [15:0] blueRaw;
    } colorSample;

    // final 16-bit channel levels
    typedef struct packed {
        logic [15:0] red;
        logic [15:0] green;
        logic [15:0] blue;
        logic [15:0] white;
    } lampLevels;

endpackage

//--- design/cmdCapture.sv
/*
 * cmdCapture: samples the command inputs, decodes the mode byte and
 * launches one job whenever the hue ramp is idle
 */
`include "lamp_macros.svh"

module cmdCapture (
    input  logic            clk,
    input  logic            reset_sig,
    input  logic [7:0]      mode,
    input  logic [7:0]      intensity,
    input  logic [7:0]      colorIdx,
    input  logic [15:0]     whiteIn,
    input  logic [15:0]     redIn,
    input  logic [15:0]     greenIn,
    input  logic [15:0]     blueIn,
    input  logic            rampBusy,
    output lampPkg::lampJob job,
    output logic            jobValid
);
    import lampPkg::*;

    // sampled command
    logic [7:0]  modeQ;
    logic [7:0]  intensityQ;
    logic [7:0]  colorIdxQ;
    logic [15:0] whiteQ;
    logic [15:0] redQ;
    logic [15:0] greenQ;
    logic [15:0] blueQ;

    lampOp opDec;
    logic  modeKnown;
    logic  launch;

    // mode decode, unknown codes never launch
    always_comb begin
        modeKnown = 1'b1;
        case (modeQ)
            `LAMP_MODE_PASS:  opDec = opPass;
            `LAMP_MODE_WHEEL: opDec = opWheel;
            default: begin
                opDec = opPass;
                modeKnown = 1'b0;
            end
        endcase
    end

    // rampBusy only rises a cycle after a wheel job leaves here
    // so our own last launch covers that gap
    assign launch = modeKnown && !rampBusy && !(jobValid && job.op == opWheel);

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            modeQ <= 8'h00;
            jobValid <= 1'b0;
        end else begin
            modeQ <= mode;
            jobValid <= launch;
        end
    end

    // payload, sampled every edge
    always_ff @(posedge clk) begin
        intensityQ <= intensity;
        colorIdxQ <= colorIdx;
        whiteQ <= whiteIn;
        redQ <= redIn;
        greenQ <= greenIn;
        blueQ <= blueIn;
        if (launch) begin
            job <= '{op: opDec, intensity: intensityQ, colorIdx: colorIdxQ,
                     whiteLvl: whiteQ, redLvl: redQ, greenLvl: greenQ, blueLvl: blueQ};
        end
    end

endmodule

//--- design/hueRamp.sv
/*
 * hueRamp: walks the seven-segment colour wheel one position per cycle
 * up to colorIdx, passthrough jobs go straight through in one cycle
 */
`include "lamp_macros.svh"

module hueRamp (
    input  logic                clk,
    input  logic                reset_sig,
    input  lampPkg::lampJob     job,
    input  logic                jobValid,
    output lampPkg::colorSample sample,
    output logic                sampleValid,
    output logic                rampBusy
);
    import lampPkg::*;

    rampState state;
    lampJob   jobQ;

    // wheel position, segment and offset inside the segment
    logic [7:0] pos;
    logic [2:0] seg;
    logic [5:0] segOff;

    // running colour
    logic [7:0] wheelR;
    logic [7:0] wheelG;
    logic [7:0] wheelB;
    logic [7:0] nextR;
    logic [7:0] nextG;
    logic [7:0] nextB;
    logic       segFirst;
    logic       segEnd;

    // rising channel, restarts from zero at a segment start
    function automatic logic [7:0] stepUp(input logic [7:0] cur, input logic first);
        logic [8:0] sum;
        sum = (first ? 9'd0 : {1'b0, cur}) + {1'b0, `HUE_STEP};
        return (sum > 9'd255) ? 8'hFF : sum[7:0];
    endfunction

    // falling channel, restarts from full scale at a segment start
    function automatic logic [7:0] stepDown(input logic [7:0] cur, input logic first);
        logic [7:0] base;
        base = first ? 8'hFF : cur;
        return (base < `HUE_STEP) ? 8'h00 : base - `HUE_STEP;
    endfunction

    assign segFirst = (segOff == 6'd0);
    assign segEnd = (segOff == `HUE_SEG_LEN - 6'd1);

    // colour at the current position
    always_comb begin
        case (seg)
            3'd0: begin
                nextR = 8'hFF;
                nextG = 8'h00;
                nextB = stepUp(wheelB, segFirst);
            end
            3'd1: begin
                nextR = stepDown(wheelR, segFirst);
                nextG = 8'h00;
                nextB = 8'hFF;
            end
            3'd2: begin
                nextR = 8'h00;
                nextG = stepUp(wheelG, segFirst);
                nextB = 8'hFF;
            end
            3'd3: begin
                nextR = 8'h00;
                nextG = 8'hFF;
                nextB = stepDown(wheelB, segFirst);
            end
            3'd4: begin
                nextR = stepUp(wheelR, segFirst);
                nextG = 8'hFF;
                nextB = 8'h00;
            end
            3'd5: begin
                nextR = 8'hFF;
                nextG = stepDown(wheelG, segFirst);
                nextB = 8'h00;
            end
            // last segment holds pure red
            default: begin
                nextR = 8'hFF;
                nextG = 8'h00;
                nextB = 8'h00;
            end
        endcase
    end

    // busy from the first step until the sample leaves
    assign rampBusy = (state != rsIdle);

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            state <= rsIdle;
            sampleValid <= 1'b0;
            pos <= 8'd0;
            seg <= 3'd0;
            segOff <= 6'd0;
        end else begin
            sampleValid <= 1'b0;
            case (state)
                rsIdle: begin
                    if (jobValid && job.op == opWheel) begin
                        state <= rsStep;
                        pos <= 8'd0;
                        seg <= 3'd0;
                        segOff <= 6'd0;
                    end else if (jobValid) begin
                        sampleValid <= 1'b1;
                    end
                end
                rsStep: begin
                    if (pos == jobQ.colorIdx) begin
                        state <= rsDone;
                    end else begin
                        pos <= pos + 8'd1;
                        // move to the next segment, the last one just keeps counting
                        if (segEnd && seg != `HUE_LAST_SEG) begin
                            seg <= seg + 3'd1;
                            segOff <= 6'd0;
                        end else begin
                            segOff <= segOff + 6'd1;
                        end
                    end
                end
                rsDone: begin
                    sampleValid <= 1'b1;
                    state <= rsIdle;
                end
                default: state <= rsIdle;
            endcase
        end
    end

    // job, colour and output payload
    always_ff @(posedge clk) begin
        if (state == rsIdle && jobValid) begin
            jobQ <= job;
        end
        if (state == rsStep) begin
            wheelR <= nextR;
            wheelG <= nextG;
            wheelB <= nextB;
        end
        if (state == rsIdle && jobValid && job.op == opPass) begin
            sample <= '{op: opPass, intensity: job.intensity, red: 8'h00, green: 8'h00,
                        blue: 8'h00, white: job.whiteLvl[7:0], whiteRaw: job.whiteLvl,
                        redRaw: job.redLvl, greenRaw: job.greenLvl, blueRaw: job.blueLvl};
        end else if (state == rsDone) begin
            sample <= '{op: opWheel, intensity: jobQ.intensity, red: wheelR, green: wheelG,
                        blue: wheelB, white: jobQ.whiteLvl[7:0], whiteRaw: jobQ.whiteLvl,
                        redRaw: jobQ.redLvl, greenRaw: jobQ.greenLvl, blueRaw: jobQ.blueLvl};
        end
    end

endmodule

//--- design/whiteMix.sv
/*
 * whiteMix: adds the white level to red, green and blue with clipping
 */
module whiteMix (
    input  logic                clk,
    input  logic                reset_sig,
    input  lampPkg::colorSample sample,
    input  logic                sampleValid,
    output lampPkg::colorSample mixed,
    output logic                mixValid
);
    import lampPkg::*;

    // 8-bit add, clipped at full scale
    function automatic logic [7:0] clipAdd(input logic [7:0] a, input logic [7:0] b);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[8] ? 8'hFF : sum[7:0];
    endfunction

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            mixValid <= 1'b0;
        end else begin
            mixValid <= sampleValid;
        end
    end

    always_ff @(posedge clk) begin
        if (sampleValid) begin
            mixed <= sample;
            // passthrough keeps its raw levels untouched
            if (sample.op == opWheel) begin
                mixed.red <= clipAdd(sample.red, sample.white);
                mixed.green <= clipAdd(sample.green, sample.white);
                mixed.blue <= clipAdd(sample.blue, sample.white);
            end
        end
    end

endmodule

//--- design/dimmer.sv
/*
 * dimmer: scales the four channels by intensity into 16-bit output levels
 * and strobes each new result
 */
module dimmer (
    input  logic                clk,
    input  logic                reset_sig,
    input  lampPkg::colorSample mixed,
    input  logic                mixValid,
    output lampPkg::lampLevels  levels,
    output logic                levelStrobe
);
    import lampPkg::*;

    lampLevels nextLevels;

    // 8x8 product, full 16-bit result
    function automatic logic [15:0] scale(input logic [7:0] lvl, input logic [7:0] gain);
        logic [15:0] prod;
        prod = {8'd0, lvl} * {8'd0, gain};
        return prod;
    endfunction

    // wheel jobs get dimmed, passthrough takes the raw inputs
    always_comb begin
        if (mixed.op == opWheel) begin
            nextLevels.red = scale(mixed.red, mixed.intensity);
            nextLevels.green = scale(mixed.green, mixed.intensity);
            nextLevels.blue = scale(mixed.blue, mixed.intensity);
            nextLevels.white = scale(mixed.white, mixed.intensity);
        end else begin
            nextLevels.red = mixed.redRaw;
            nextLevels.green = mixed.greenRaw;
            nextLevels.blue = mixed.blueRaw;
            nextLevels.white = mixed.whiteRaw;
        end
    end

    // output register, held between jobs
    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            levels <= '0;
            levelStrobe <= 1'b0;
        end else begin
            levelStrobe <= mixValid;
            if (mixValid) begin
                levels <= nextLevels;
            end
        end
    end

endmodule

//--- design/lampPipeline.sv
/*
 * lampPipeline: RGBW lamp colour pipeline top, capture, hue ramp,
 * white mix and dimmer in a chain
 */
module lampPipeline (
    input  logic        clk,
    input  logic        reset_sig,
    input  logic [7:0]  mode,
    input  logic [7:0]  intensity,
    input  logic [7:0]  colorIdx,
    input  logic [15:0] whiteIn,
    input  logic [15:0] redIn,
    input  logic [15:0] greenIn,
    input  logic [15:0] blueIn,
    output logic [15:0] redOut,
    output logic [15:0] greenOut,
    output logic [15:0] blueOut,
    output logic [15:0] whiteOut,
    output logic        levelStrobe
);
    import lampPkg::*;

    lampJob     job;
    logic       jobValid;
    logic       rampBusy;
    colorSample sample;
    logic       sampleValid;
    colorSample mixed;
    logic       mixValid;
    lampLevels  levels;

    // stage 1, command sampling and mode decode
    cmdCapture uCapture (
        .clk        (clk),
        .reset_sig  (reset_sig),
        .mode       (mode),
        .intensity  (intensity),
        .colorIdx   (colorIdx),
        .whiteIn    (whiteIn),
        .redIn      (redIn),
        .greenIn    (greenIn),
        .blueIn     (blueIn),
        .rampBusy   (rampBusy),
        .job        (job),
        .jobValid   (jobValid)
    );

    // stage 2, colour wheel walk
    hueRamp uRamp (
        .clk         (clk),
        .reset_sig   (reset_sig),
        .job         (job),
        .jobValid    (jobValid),
        .sample      (sample),
        .sampleValid (sampleValid),
        .rampBusy    (rampBusy)
    );

    // stage 3, white addition
    whiteMix uMix (
        .clk         (clk),
        .reset_sig   (reset_sig),
        .sample      (sample),
        .sampleValid (sampleValid),
        .mixed       (mixed),
        .mixValid    (mixValid)
    );

    // stage 4, intensity scaling and output register
    dimmer uDimmer (
        .clk         (clk),
        .reset_sig   (reset_sig),
        .mixed       (mixed),
        .mixValid    (mixValid),
        .levels      (levels),
        .levelStrobe (levelStrobe)
    );

    assign redOut = levels.red;
    assign greenOut = levels.green;
    assign blueOut = levels.blue;
    assign whiteOut = levels.white;

endmodule

//--- verification/lampPipelineTb.sv
/*
 * lampPipelineTb drives random and directed commands into the RGBW lamp pipeline
 * and checks the outputs against a reference colour wheel on every levelStrobe
 */
`include "lamp_macros.svh"

module lampPipelineTb;
    timeunit 1ns;
    timeprecision 100ps;

    import lampPkg::*;

    // about three times 25 wheel jobs of up to ~265 cycles
    // plus the passthrough bursts
    localparam int CYCLE_LIMIT = 20000;

    // expected result of one accepted command
    typedef struct packed {
        lampLevels   levels;
        logic        isPass;
        logic [31:0] dueCycle;
    } expEntry;

    logic        clk;
    logic        reset_sig;
    logic [7:0]  mode;
    logic [7:0]  intensity;
    logic [7:0]  colorIdx;
    logic [15:0] whiteIn;
    logic [15:0] redIn;
    logic [15:0] greenIn;
    logic [15:0] blueIn;
    logic [15:0] redOut;
    logic [15:0] greenOut;
    logic [15:0] blueOut;
    logic [15:0] whiteOut;
    logic        levelStrobe;

    int          cycle = 0;
    logic [31:0] rngState = 32'd4;
    expEntry     expQ[$];
    lampLevels   lastLevels = '0;

    lampPipeline DUT (
        .clk(clk), .reset_sig(reset_sig), .mode(mode), .intensity(intensity),
        .colorIdx(colorIdx), .whiteIn(whiteIn), .redIn(redIn), .greenIn(greenIn),
        .blueIn(blueIn), .redOut(redOut), .greenOut(greenOut), .blueOut(blueOut),
        .whiteOut(whiteOut), .levelStrobe(levelStrobe)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    task automatic failAndStop();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic valueError(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        failAndStop();
    endtask

    // cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
            failAndStop();
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // any byte except the two mode codes
    function automatic logic [7:0] unknownMode();
        logic [31:0] r;
        r = nextRand();
        if (r[7:0] == `LAMP_MODE_PASS || r[7:0] == `LAMP_MODE_WHEEL)
            return r[7:0] ^ 8'h01;
        return r[7:0];
    endfunction

    // wheel position straight to {red, green, blue}
    function automatic logic [23:0] wheelColor(input logic [7:0] p);
        int s;
        int k;
        int v;
        int d;
        s = int'(p) / 36;
        if (s > 6)
            s = 6;
        k = int'(p) - 36 * s;
        v = 7 * (k + 1);
        if (v > 255)
            v = 255;
        d = 255 - 7 * (k + 1);
        if (d < 0)
            d = 0;
        case (s)
            0: return {8'hFF, 8'h00, v[7:0]};
            1: return {d[7:0], 8'h00, 8'hFF};
            2: return {8'h00, v[7:0], 8'hFF};
            3: return {8'h00, 8'hFF, d[7:0]};
            4: return {v[7:0], 8'hFF, 8'h00};
            5: return {8'hFF, d[7:0], 8'h00};
            default: return {8'hFF, 8'h00, 8'h00};
        endcase
    endfunction

    // wheel colour with the clipped white add and dimming on top
    function automatic lampLevels wheelLevels(input logic [7:0] inten, input logic [7:0] idx,
                                              input logic [7:0] w);
        logic [23:0] rgb;
        int          sum;
        lampLevels   lv;
        rgb = wheelColor(idx);
        for (int c = 0; c < 3; c++) begin
            sum = int'(rgb[8*c +: 8]) + int'(w);
            if (sum > 255)
                sum = 255;
            // c runs from blue up to red
            lv[16*(c+1) +: 16] = 16'(inten) * 16'(sum[7:0]);
        end
        lv.white = 16'(inten) * 16'(w);
        return lv;
    endfunction

    task automatic driveCmd(input logic [7:0] m, input logic [7:0] inten, input logic [7:0] idx,
                            input logic [15:0] w, input logic [15:0] r, input logic [15:0] g,
                            input logic [15:0] b);
        @(posedge clk);
        #2;
        mode = m;
        intensity = inten;
        colorIdx = idx;
        whiteIn = w;
        redIn = r;
        greenIn = g;
        blueIn = b;
    endtask

    task automatic driveRandom(input logic [7:0] m);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = nextRand();
        b = nextRand();
        c = nextRand();
        driveCmd(m, a[7:0], a[15:8], a[31:16], b[15:0], b[31:16], c[15:0]);
    endtask

    // idle cycles until every expected strobe has been seen
    task automatic waitDrained();
        while (expQ.size() != 0)
            driveRandom(unknownMode());
    endtask

    task automatic sendPass();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        expEntry     e;
        a = nextRand();
        b = nextRand();
        c = nextRand();
        driveCmd(`LAMP_MODE_PASS, a[7:0], a[15:8], a[31:16], b[15:0], b[31:16], c[15:0]);
        e.levels = {b[15:0], b[31:16], c[15:0], a[31:16]};
        e.isPass = 1'b1;
        // sampled on the next edge and strobed 4 edges after that
        e.dueCycle = 32'(cycle + 5);
        expQ.push_back(e);
    endtask

    task automatic sendWheel(input logic [7:0] inten, input logic [7:0] idx, input logic [7:0] w);
        logic [31:0] a;
        logic [31:0] pick;
        expEntry     e;
        int          i;
        a = nextRand();
        driveCmd(`LAMP_MODE_WHEEL, inten, idx, {a[31:24], w}, a[15:0], a[23:8], a[31:16]);
        e.levels = wheelLevels(inten, idx, w);
        e.isPass = 1'b0;
        e.dueCycle = '0;
        expQ.push_back(e);
        // known modes must all be ignored while the ramp walks
        for (i = 0; i < int'(idx) + 3; i++) begin
            pick = nextRand();
            case (pick[1:0])
                2'd0: driveRandom(`LAMP_MODE_PASS);
                2'd1: driveRandom(`LAMP_MODE_WHEEL);
                default: driveRandom(pick[15:8]);
            endcase
        end
        waitDrained();
    endtask

    task automatic checkLevels(input lampLevels exp);
        assert (redOut == exp.red) else valueError("redOut", 32'(redOut), 32'(exp.red));
        assert (greenOut == exp.green) else valueError("greenOut", 32'(greenOut), 32'(exp.green));
        assert (blueOut == exp.blue) else valueError("blueOut", 32'(blueOut), 32'(exp.blue));
        assert (whiteOut == exp.white) else valueError("whiteOut", 32'(whiteOut), 32'(exp.white));
    endtask

    task automatic checkStrobe();
        expEntry e;
        if (expQ.size() == 0) begin
            $display("levelStrobe pulsed while no command was pending");
            failAndStop();
        end else begin
            e = expQ.pop_front();
            if (e.isPass)
                assert (32'(cycle) == e.dueCycle)
                    else valueError("levelStrobe cycle", 32'(cycle), e.dueCycle);
            checkLevels(e.levels);
            lastLevels = e.levels;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset_sig && cycle > 0) begin
            assert (!levelStrobe) else valueError("levelStrobe", 32'(levelStrobe), 32'd0);
            checkLevels('0);
        end else if (reset_sig && levelStrobe) begin
            checkStrobe();
        end else if (reset_sig) begin
            // the outputs hold without a strobe
            checkLevels(lastLevels);
        end
    end

    initial begin
        int          i;
        logic [31:0] r;
        clk = 1'b0;
        reset_sig = 1'b0;
        mode = 8'h00;
        intensity = 8'h00;
        colorIdx = 8'h00;
        whiteIn = 16'h0000;
        redIn = 16'h0000;
        greenIn = 16'h0000;
        blueIn = 16'h0000;
        repeat (10) @(posedge clk);
        #2;
        reset_sig = 1'b1;
        repeat (3) driveRandom(unknownMode());

        // passthrough back to back then spaced out
        for (i = 0; i < 40; i++)
            sendPass();
        waitDrained();
        for (i = 0; i < 5; i++) begin
            sendPass();
            driveRandom(unknownMode());
        end
        waitDrained();

        // wheel segment edges at unit intensity and no white
        sendWheel(8'd1, 8'd0, 8'd0);
        sendWheel(8'd1, 8'd35, 8'd0);
        sendWheel(8'd1, 8'd36, 8'd0);
        sendWheel(8'd1, 8'd107, 8'd0);
        sendWheel(8'd1, 8'd215, 8'd0);
        sendWheel(8'd1, 8'd216, 8'd0);
        sendWheel(8'd1, 8'd255, 8'd0);
        for (i = 0; i < 6; i++) begin
            r = nextRand();
            sendWheel(8'd1, r[7:0], 8'd0);
        end

        // white mix and dimming where the first two cases clip at 255
        sendWheel(8'hFF, 8'd100, 8'hC8);
        sendWheel(8'h80, 8'd10, 8'hFF);
        for (i = 0; i < 8; i++) begin
            r = nextRand();
            sendWheel(r[7:0], r[15:8], r[23:16]);
        end

        // outputs must hold through unknown modes
        repeat (20) driveRandom(unknownMode());

        // passthrough straight after a wheel job
        sendWheel(8'h40, 8'd50, 8'h10);
        sendPass();
        sendWheel(8'hC0, 8'd200, 8'h20);
        sendPass();
        waitDrained();
        repeat (5) driveRandom(unknownMode());

        $display("Verification passed");
        $finish;
    end

endmodule

//--- all.f
+incdir+include
design/lampPkg.sv
design/cmdCapture.sv
design/hueRamp.sv
design/whiteMix.sv
design/dimmer.sv
design/lampPipeline.sv
verification/lampPipelineTb.sv

//--- run.sh
#!/bin/sh
# build and run the lamp pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f all.f \
    --top-module lampPipelineTb -Mdir obj_dir -o simLamp
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simLamp > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Verification passed" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi
